// File: logic/sdma_pkg.sv
// SDMA shared definitions
`default_nettype none

package sdma_pkg;

  localparam int ADDR_W     = 32;
  localparam int BEAT_BYTES = 8;
  localparam int DATA_W     = BEAT_BYTES * 8;
  localparam int LEN_W      = 16;
  localparam int FIFO_DEPTH = 4;

  // Port codes
  localparam logic [1:0] PORT_DC1 = 2'd0;
  localparam logic [1:0] PORT_DC2 = 2'd1;
  localparam logic [1:0] PORT_WC  = 2'd2;

  // Weight port windows
  localparam logic [ADDR_W-1:0] WMEM_SADDR = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] WMEM_EADDR = 32'h0000_0FFF;
  localparam logic [ADDR_W-1:0] BMEM_SADDR = 32'h0000_1000;
  localparam logic [ADDR_W-1:0] BMEM_EADDR = 32'h0000_13FF;

  typedef struct packed {
    logic [1:0]        src_port;
    logic [1:0]        dst_port;
    logic [ADDR_W-1:0] src_addr;
    logic [ADDR_W-1:0] dst_addr;
    logic [LEN_W-1:0]  length;
    logic              shuffle_en;
    logic [2:0]        shuffle_idx;
  } sdma_inst_t;

  typedef struct packed {
    logic [BEAT_BYTES-1:0] ena;
    logic                  wea;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  ready;
    logic [DATA_W-1:0]     rdata;
    logic [BEAT_BYTES-1:0] rvld;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: logic/sdma_top_ctrl.sv
// SDMA instruction control
`default_nettype none

module sdma_top_ctrl (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset,
  input  wire sdma_pkg::sdma_inst_t i_inst,
  input  wire logic                 i_inst_vld,
  input  wire logic                 i_wr_last,
  output logic                      o_ready,
  output sdma_pkg::sdma_inst_t      o_inst,
  output logic                      o_start
);

  logic accept;

  assign accept = i_inst_vld && o_ready;

  // Idle until an instruction lands and busy until the last write
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ready <= 1'b1;
      o_start <= 1'b0;
      o_inst  <= '0;
    end else begin
      o_start <= accept;
      if (accept) begin
        o_inst  <= i_inst;
        o_ready <= 1'b0;
      end else if (i_wr_last) begin
        o_ready <= 1'b1;
      end
    end
  end

  // --------------------
  a_nonzero_length: assert property (
    @(posedge i_clk) disable iff (i_reset)
    accept |-> (i_inst.length != '0)
  );

endmodule

`default_nettype wire

// File: logic/sdma_addr_path.sv
// SDMA address generation
`default_nettype none

module sdma_addr_path (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset,
  input  wire sdma_pkg::sdma_inst_t          i_inst,
  input  wire logic                          i_start,
  input  wire logic                          i_src_ready,
  input  wire logic                          i_pop,
  output sdma_pkg::mem_req_t                 o_rd_req,
  output logic [sdma_pkg::ADDR_W-1:0]        o_wr_addr,
  output logic [sdma_pkg::BEAT_BYTES-1:0]    o_wr_ena
);

  localparam int CRED_W = $clog2(sdma_pkg::FIFO_DEPTH + 1);

  logic [sdma_pkg::LEN_W-1:0]      beats;
  logic [sdma_pkg::BEAT_BYTES-1:0] last_ena;
  logic [sdma_pkg::LEN_W-1:0]      rd_left;
  logic [sdma_pkg::LEN_W-1:0]      wr_left;
  logic [sdma_pkg::ADDR_W-1:0]     rd_addr;
  logic [CRED_W-1:0]               credit;
  logic                            rd_go;
  logic                            rd_fire;

  // Beat count rounded up and the tail strobe from length mod 8
  assign beats    = (i_inst.length >> 3) + sdma_pkg::LEN_W'(|i_inst.length[2:0]);
  assign last_ena = (i_inst.length[2:0] == 3'd0) ? '1 :
                    ~({sdma_pkg::BEAT_BYTES{1'b1}} << i_inst.length[2:0]);

  // Credits cover beats in flight plus beats buffered
  assign rd_go   = (rd_left != '0) && (credit < CRED_W'(sdma_pkg::FIFO_DEPTH));
  assign rd_fire = (|o_rd_req.ena) && i_src_ready;

  always_comb begin
    o_rd_req      = '0;
    o_rd_req.addr = rd_addr;
    if (rd_go) begin
      o_rd_req.ena = (rd_left == sdma_pkg::LEN_W'(1)) ? last_ena : '1;
    end
  end

  assign o_wr_ena = (wr_left == '0) ? '0 :
                    (wr_left == sdma_pkg::LEN_W'(1)) ? last_ena : '1;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rd_left   <= '0;
      wr_left   <= '0;
      rd_addr   <= '0;
      o_wr_addr <= '0;
      credit    <= '0;
    end else begin
      if (i_start) begin
        rd_left   <= beats;
        wr_left   <= beats;
        rd_addr   <= i_inst.src_addr;
        o_wr_addr <= i_inst.dst_addr;
      end else begin
        if (rd_fire) begin
          rd_left <= rd_left - 1'b1;
          rd_addr <= rd_addr + sdma_pkg::ADDR_W'(sdma_pkg::BEAT_BYTES);
        end
        if (i_pop) begin
          wr_left   <= wr_left - 1'b1;
          o_wr_addr <= o_wr_addr + sdma_pkg::ADDR_W'(sdma_pkg::BEAT_BYTES);
        end
      end
      credit <= credit + CRED_W'(rd_fire) - CRED_W'(i_pop);
    end
  end

  // --------------------
  a_credit_limit: assert property (
    @(posedge i_clk) disable iff (i_reset)
    credit <= CRED_W'(sdma_pkg::FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// File: logic/sdma_data_path.sv
// SDMA beat buffer and write issue
`default_nettype none

module sdma_data_path (
  input  wire logic                          i_clk,
  input  wire logic                          i_reset,
  input  wire sdma_pkg::sdma_inst_t          i_inst,
  input  wire logic [sdma_pkg::DATA_W-1:0]   i_rdata,
  input  wire logic [sdma_pkg::BEAT_BYTES-1:0] i_rvld,
  input  wire logic                          i_dst_ready,
  input  wire logic [sdma_pkg::ADDR_W-1:0]   i_wr_addr,
  input  wire logic [sdma_pkg::BEAT_BYTES-1:0] i_wr_ena,
  output sdma_pkg::mem_req_t                 o_wr_req,
  output logic                               o_pop,
  output logic                               o_wr_last
);

  localparam int PTR_W = $clog2(sdma_pkg::FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [sdma_pkg::DATA_W-1:0] fifo_mem [sdma_pkg::FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            count;
  logic                        push;
  logic [sdma_pkg::DATA_W-1:0] head;
  logic [sdma_pkg::DATA_W-1:0] shuffled;
  logic [2:0]                  sel;
  logic [sdma_pkg::LEN_W-1:0]  beats;
  logic [sdma_pkg::LEN_W-1:0]  wr_cnt;

  assign push  = |i_rvld;
  assign head  = fifo_mem[rd_ptr];
  assign beats = (i_inst.length >> 3) + sdma_pkg::LEN_W'(|i_inst.length[2:0]);

  always_ff @(posedge i_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= i_rdata;
    end
  end

  // --------------------
  // Byte k takes head byte (k + idx) mod 8
  always_comb begin
    shuffled = '0;
    sel      = '0;
    for (int k = 0; k < sdma_pkg::BEAT_BYTES; k++) begin
      sel = 3'(k) + i_inst.shuffle_idx;
      shuffled[8*k +: 8] = head[8*sel +: 8];
    end
  end

  always_comb begin
    o_wr_req       = '0;
    o_wr_req.addr  = i_wr_addr;
    o_wr_req.wdata = i_inst.shuffle_en ? shuffled : head;
    if (count != '0) begin
      o_wr_req.ena = i_wr_ena;
      o_wr_req.wea = 1'b1;
    end
  end

  assign o_pop     = (|o_wr_req.ena) && i_dst_ready;
  assign o_wr_last = o_pop && (wr_cnt == beats - 1'b1);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      wr_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (o_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(o_pop);
      if (o_wr_last) begin
        wr_cnt <= '0;
      end else if (o_pop) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  // Read credits upstream keep the buffer from overrunning
  a_no_overflow: assert property (
    @(posedge i_clk) disable iff (i_reset)
    push |-> (count != CNT_W'(sdma_pkg::FIFO_DEPTH))
  );

endmodule

`default_nettype wire

// File: logic/sdma_port_mux.sv
// SDMA port steering
`default_nettype none

module sdma_port_mux (
  input  wire sdma_pkg::sdma_inst_t i_inst,
  input  wire sdma_pkg::mem_req_t   i_rd_req,
  input  wire sdma_pkg::mem_req_t   i_wr_req,
  input  wire sdma_pkg::mem_rsp_t   i_dc1_rsp,
  input  wire sdma_pkg::mem_rsp_t   i_dc2_rsp,
  input  wire sdma_pkg::mem_rsp_t   i_wc_rsp,
  output sdma_pkg::mem_req_t        o_dc1_req,
  output sdma_pkg::mem_req_t        o_dc2_req,
  output sdma_pkg::mem_req_t        o_wc_req,
  output sdma_pkg::mem_rsp_t        o_src_rsp,
  output logic                      o_dst_ready
);

  // Reads go to the source, writes to the destination
  always_comb begin
    o_dc1_req = '0;
    o_dc2_req = '0;
    o_wc_req  = '0;
    case (i_inst.src_port)
      sdma_pkg::PORT_DC1: o_dc1_req = i_rd_req;
      sdma_pkg::PORT_DC2: o_dc2_req = i_rd_req;
      sdma_pkg::PORT_WC:  o_wc_req  = i_rd_req;
      default: ;
    endcase
    case (i_inst.dst_port)
      sdma_pkg::PORT_DC1: o_dc1_req = i_wr_req;
      sdma_pkg::PORT_DC2: o_dc2_req = i_wr_req;
      sdma_pkg::PORT_WC:  o_wc_req  = i_wr_req;
      default: ;
    endcase
  end

  always_comb begin
    o_src_rsp   = '0;
    o_dst_ready = 1'b0;
    case (i_inst.src_port)
      sdma_pkg::PORT_DC1: o_src_rsp = i_dc1_rsp;
      sdma_pkg::PORT_DC2: o_src_rsp = i_dc2_rsp;
      sdma_pkg::PORT_WC:  o_src_rsp = i_wc_rsp;
      default: ;
    endcase
    case (i_inst.dst_port)
      sdma_pkg::PORT_DC1: o_dst_ready = i_dc1_rsp.ready;
      sdma_pkg::PORT_DC2: o_dst_ready = i_dc2_rsp.ready;
      sdma_pkg::PORT_WC:  o_dst_ready = i_wc_rsp.ready;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/sdma_window_demux.sv
// Weight port window decoder
`default_nettype none

module sdma_window_demux (
  input  wire logic               i_clk,
  input  wire logic               i_reset,
  input  wire sdma_pkg::mem_req_t i_wc_req,
  input  wire sdma_pkg::mem_rsp_t i_wmem_rsp,
  input  wire sdma_pkg::mem_rsp_t i_bmem_rsp,
  output sdma_pkg::mem_req_t      o_wmem_req,
  output sdma_pkg::mem_req_t      o_bmem_req,
  output sdma_pkg::mem_rsp_t      o_wc_rsp
);

  logic req_vld;
  logic in_wmem;
  logic in_bmem;
  logic rd_bmem;

  assign req_vld = |i_wc_req.ena;
  assign in_wmem = (i_wc_req.addr >= sdma_pkg::WMEM_SADDR) &&
                   (i_wc_req.addr <= sdma_pkg::WMEM_EADDR);
  assign in_bmem = (i_wc_req.addr >= sdma_pkg::BMEM_SADDR) &&
                   (i_wc_req.addr <= sdma_pkg::BMEM_EADDR);

  // Window-relative addresses
  always_comb begin
    o_wmem_req = '0;
    o_bmem_req = '0;
    if (req_vld && in_bmem) begin
      o_bmem_req      = i_wc_req;
      o_bmem_req.addr = i_wc_req.addr - sdma_pkg::BMEM_SADDR;
    end else if (req_vld) begin
      o_wmem_req      = i_wc_req;
      o_wmem_req.addr = i_wc_req.addr - sdma_pkg::WMEM_SADDR;
    end
  end

  // A transfer stays in one window, so the last read target steers data back
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rd_bmem <= 1'b0;
    end else if (req_vld && !i_wc_req.wea && o_wc_rsp.ready) begin
      rd_bmem <= in_bmem;
    end
  end

  assign o_wc_rsp.ready = in_bmem ? i_bmem_rsp.ready : i_wmem_rsp.ready;
  assign o_wc_rsp.rdata = rd_bmem ? i_bmem_rsp.rdata : i_wmem_rsp.rdata;
  assign o_wc_rsp.rvld  = rd_bmem ? i_bmem_rsp.rvld  : i_wmem_rsp.rvld;

  // --------------------
  a_in_window: assert property (
    @(posedge i_clk) disable iff (i_reset)
    req_vld |-> (in_wmem || in_bmem)
  );

endmodule

`default_nettype wire

// File: logic/sdma_top.sv
// SDMA move engine top
`default_nettype none

module sdma_top (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset,
  input  wire sdma_pkg::sdma_inst_t i_inst,
  input  wire logic                 i_inst_vld,
  output logic                      o_ready,
  output sdma_pkg::mem_req_t        o_dc1_req,
  input  wire sdma_pkg::mem_rsp_t   i_dc1_rsp,
  output sdma_pkg::mem_req_t        o_dc2_req,
  input  wire sdma_pkg::mem_rsp_t   i_dc2_rsp,
  output sdma_pkg::mem_req_t        o_wmem_req,
  input  wire sdma_pkg::mem_rsp_t   i_wmem_rsp,
  output sdma_pkg::mem_req_t        o_bmem_req,
  input  wire sdma_pkg::mem_rsp_t   i_bmem_rsp
);

  sdma_pkg::sdma_inst_t              inst;
  logic                              start;
  logic                              wr_last;
  logic                              pop;
  logic                              dst_ready;
  logic [sdma_pkg::ADDR_W-1:0]       wr_addr;
  logic [sdma_pkg::BEAT_BYTES-1:0]   wr_ena;
  sdma_pkg::mem_req_t                rd_req;
  sdma_pkg::mem_req_t                wr_req;
  sdma_pkg::mem_req_t                wc_req;
  sdma_pkg::mem_rsp_t                src_rsp;
  sdma_pkg::mem_rsp_t                wc_rsp;

  sdma_top_ctrl u_sdma_top_ctrl (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_inst     (i_inst),
    .i_inst_vld (i_inst_vld),
    .i_wr_last  (wr_last),
    .o_ready    (o_ready),
    .o_inst     (inst),
    .o_start    (start)
  );

  sdma_addr_path u_sdma_addr_path (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_inst      (inst),
    .i_start     (start),
    .i_src_ready (src_rsp.ready),
    .i_pop       (pop),
    .o_rd_req    (rd_req),
    .o_wr_addr   (wr_addr),
    .o_wr_ena    (wr_ena)
  );

  sdma_data_path u_sdma_data_path (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_inst      (inst),
    .i_rdata     (src_rsp.rdata),
    .i_rvld      (src_rsp.rvld),
    .i_dst_ready (dst_ready),
    .i_wr_addr   (wr_addr),
    .i_wr_ena    (wr_ena),
    .o_wr_req    (wr_req),
    .o_pop       (pop),
    .o_wr_last   (wr_last)
  );

  sdma_port_mux u_sdma_port_mux (
    .i_inst      (inst),
    .i_rd_req    (rd_req),
    .i_wr_req    (wr_req),
    .i_dc1_rsp   (i_dc1_rsp),
    .i_dc2_rsp   (i_dc2_rsp),
    .i_wc_rsp    (wc_rsp),
    .o_dc1_req   (o_dc1_req),
    .o_dc2_req   (o_dc2_req),
    .o_wc_req    (wc_req),
    .o_src_rsp   (src_rsp),
    .o_dst_ready (dst_ready)
  );

  sdma_window_demux u_sdma_window_demux (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_wc_req   (wc_req),
    .i_wmem_rsp (i_wmem_rsp),
    .i_bmem_rsp (i_bmem_rsp),
    .o_wmem_req (o_wmem_req),
    .o_bmem_req (o_bmem_req),
    .o_wc_rsp   (wc_rsp)
  );

endmodule

`default_nettype wire

// File: testbench/tb_sdma_mem.sv
// Byte-addressed memory model
`default_nettype none

module tb_sdma_mem #(
  parameter int MEM_ID    = 0,
  parameter int MEM_BYTES = 4096
) (
  input  wire logic               i_clk,
  input  wire logic               i_reset,
  input  wire logic               i_ready,
  input  wire sdma_pkg::mem_req_t i_req,
  output sdma_pkg::mem_rsp_t      o_rsp
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0]                      mem [MEM_BYTES];
  logic [sdma_pkg::DATA_W-1:0]     rd_data [2];
  logic [sdma_pkg::BEAT_BYTES-1:0] rd_vld [2];
  logic                            accept;

  // Preload byte from the whole address and the memory id
  function automatic logic [7:0] preload_byte(input logic [31:0] a);
    return a[7:0] + a[15:8] + a[23:16] + a[31:24] + 8'(37 * MEM_ID);
  endfunction

  function automatic int byte_index(input logic [31:0] a, input int k);
    return int'((a + 32'(k)) % 32'(MEM_BYTES));
  endfunction

  initial begin
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = preload_byte(32'(a));
    end
  end

  assign accept = (|i_req.ena) && i_ready;

  // Reads return through two stages and writes land on acceptance
  always @(posedge i_clk) begin
    if (i_reset) begin
      rd_vld[0] <= '0;
      rd_vld[1] <= '0;
    end else begin
      rd_vld[1]  <= rd_vld[0];
      rd_data[1] <= rd_data[0];
      rd_vld[0]  <= '0;
      if (accept && !i_req.wea) begin
        rd_vld[0] <= i_req.ena;
        for (int k = 0; k < sdma_pkg::BEAT_BYTES; k++) begin
          rd_data[0][8*k +: 8] <= mem[byte_index(i_req.addr, k)];
        end
      end
      if (accept && i_req.wea) begin
        for (int k = 0; k < sdma_pkg::BEAT_BYTES; k++) begin
          if (i_req.ena[k]) begin
            mem[byte_index(i_req.addr, k)] <= i_req.wdata[8*k +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    o_rsp.ready = i_ready;
    o_rsp.rdata = rd_data[1];
    o_rsp.rvld  = rd_vld[1];
  end

endmodule

`default_nettype wire

// File: testbench/tb_sdma_top.sv
// SDMA move engine testbench
`default_nettype none

module tb_sdma_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_HALF       = 5;
  localparam logic [31:0] LCG_MUL        = 32'd1103515245;
  localparam logic [31:0] LCG_INC        = 32'd12345;
  localparam logic [31:0] SEED           = 32'd39712;
  localparam int          TIMEOUT_MARGIN = 200;
  localparam int          MAX_TESTS      = 32;

  logic                 clk = 1'b0;
  logic                 reset;
  sdma_pkg::sdma_inst_t inst;
  logic                 inst_vld;
  logic                 ready;
  sdma_pkg::mem_req_t   dc1_req;
  sdma_pkg::mem_req_t   dc2_req;
  sdma_pkg::mem_req_t   wmem_req;
  sdma_pkg::mem_req_t   bmem_req;
  sdma_pkg::mem_rsp_t   dc1_rsp;
  sdma_pkg::mem_rsp_t   dc2_rsp;
  sdma_pkg::mem_rsp_t   wmem_rsp;
  sdma_pkg::mem_rsp_t   bmem_rsp;

  logic [31:0]          lcg_state = SEED;
  logic [3:0]           mem_ready = 4'hF;
  logic                 stall_on = 1'b0;
  int                   cycles = 0;
  int                   limit = TIMEOUT_MARGIN;
  int                   num_tests = 0;
  int                   pass_count = 0;
  int                   fail_count = 0;

  sdma_pkg::sdma_inst_t test_inst [MAX_TESTS];
  logic [8*24-1:0]      test_name [MAX_TESTS];
  logic                 test_stall [MAX_TESTS];

  always #CLK_HALF clk = ~clk;

  sdma_top i_sdma_top (
    .i_clk      (clk),
    .i_reset    (reset),
    .i_inst     (inst),
    .i_inst_vld (inst_vld),
    .o_ready    (ready),
    .o_dc1_req  (dc1_req),
    .i_dc1_rsp  (dc1_rsp),
    .o_dc2_req  (dc2_req),
    .i_dc2_rsp  (dc2_rsp),
    .o_wmem_req (wmem_req),
    .i_wmem_rsp (wmem_rsp),
    .o_bmem_req (bmem_req),
    .i_bmem_rsp (bmem_rsp)
  );

  tb_sdma_mem #(.MEM_ID(0), .MEM_BYTES(8192)) u_dc1_mem (
    .i_clk(clk), .i_reset(reset), .i_ready(mem_ready[0]), .i_req(dc1_req), .o_rsp(dc1_rsp)
  );
  tb_sdma_mem #(.MEM_ID(1), .MEM_BYTES(8192)) u_dc2_mem (
    .i_clk(clk), .i_reset(reset), .i_ready(mem_ready[1]), .i_req(dc2_req), .o_rsp(dc2_rsp)
  );
  tb_sdma_mem #(.MEM_ID(2), .MEM_BYTES(4096)) u_wmem_mem (
    .i_clk(clk), .i_reset(reset), .i_ready(mem_ready[2]), .i_req(wmem_req), .o_rsp(wmem_rsp)
  );
  tb_sdma_mem #(.MEM_ID(3), .MEM_BYTES(1024)) u_bmem_mem (
    .i_clk(clk), .i_reset(reset), .i_ready(mem_ready[3]), .i_req(bmem_req), .o_rsp(bmem_rsp)
  );

  // --------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * LCG_MUL + LCG_INC;
  endfunction

  // Each port drops ready about one cycle in four
  always @(posedge clk) begin
    #1;
    if (stall_on) begin
      lcg_state = lcg_next(lcg_state);
      for (int p = 0; p < 4; p++) begin
        mem_ready[p] = (lcg_state[16+2*p +: 2] != 2'b00);
      end
    end else begin
      mem_ready = 4'hF;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, the DUT did not finish its transfer", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------
  function automatic logic [7:0] fill_byte(input int id, input logic [31:0] a);
    return a[7:0] + a[15:8] + a[23:16] + a[31:24] + 8'(37 * id);
  endfunction

  // Preload value seen through a port with the weight port split by window
  function automatic logic [7:0] expected_fill(input logic [1:0] port, input logic [31:0] a);
    logic [7:0] b;
    case (port)
      sdma_pkg::PORT_DC1: b = fill_byte(0, a);
      sdma_pkg::PORT_DC2: b = fill_byte(1, a);
      default: begin
        if (a >= sdma_pkg::BMEM_SADDR) begin
          b = fill_byte(3, a - sdma_pkg::BMEM_SADDR);
        end else begin
          b = fill_byte(2, a);
        end
      end
    endcase
    return b;
  endfunction

  function automatic logic [7:0] read_mem_byte(input logic [1:0] port, input logic [31:0] a);
    logic [7:0] b;
    case (port)
      sdma_pkg::PORT_DC1: b = u_dc1_mem.mem[a];
      sdma_pkg::PORT_DC2: b = u_dc2_mem.mem[a];
      default: begin
        if (a >= sdma_pkg::BMEM_SADDR) begin
          b = u_bmem_mem.mem[a - sdma_pkg::BMEM_SADDR];
        end else begin
          b = u_wmem_mem.mem[a];
        end
      end
    endcase
    return b;
  endfunction

  task automatic read_patterns();
    int              fd;
    int              n;
    int              ok;
    logic [8*200-1:0] line;
    logic [8*24-1:0] nm;
    int              sp;
    int              dp;
    int              ln;
    int              se;
    int              si;
    int              st;
    logic [31:0]     sa;
    logic [31:0]     da;
    fd = $fopen("testbench/sdma_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file testbench/sdma_patterns.txt");
      fail_count++;
      return;
    end
    line = '0;
    ok = $fgets(line, fd);
    while (ok != 0) begin
      n = $sscanf(line, "%s %d %d %h %h %d %d %d %d", nm, sp, dp, sa, da, ln, se, si, st);
      if (n == 9 && num_tests < MAX_TESTS) begin
        test_name[num_tests]             = nm;
        test_inst[num_tests].src_port    = 2'(sp);
        test_inst[num_tests].dst_port    = 2'(dp);
        test_inst[num_tests].src_addr    = sa;
        test_inst[num_tests].dst_addr    = da;
        test_inst[num_tests].length      = 16'(ln);
        test_inst[num_tests].shuffle_en  = 1'(se);
        test_inst[num_tests].shuffle_idx = 3'(si);
        test_stall[num_tests]            = 1'(st);
        num_tests++;
      end
      line = '0;
      ok = $fgets(line, fd);
    end
    $fclose(fd);
  endtask

  task automatic check_reset_state();
    logic [31:0] enas;
    enas = {dc1_req.ena, dc2_req.ena, wmem_req.ena, bmem_req.ena};
    if (ready !== 1'b1) begin
      $display("[FAIL] reset_state o_ready expected 1 actual %b", ready);
      fail_count++;
    end else if (enas !== 32'h0) begin
      $display("[FAIL] reset_state ena expected %h actual %h", 32'h0, enas);
      fail_count++;
    end else begin
      $display("[PASS] reset_state");
      pass_count++;
    end
  endtask

  task automatic run_test(input int t);
    sdma_pkg::sdma_inst_t cur;
    int                   len;
    int                   k;
    int                   bad;
    logic [31:0]          a;
    logic [7:0]           exp_b;
    logic [7:0]           act_b;
    logic [31:0]          bad_addr;
    logic [7:0]           bad_exp;
    logic [7:0]           bad_act;
    cur      = test_inst[t];
    len      = int'(cur.length);
    bad      = 0;
    bad_addr = '0;
    bad_exp  = '0;
    bad_act  = '0;
    stall_on = test_stall[t];
    inst     = cur;
    inst_vld = 1'b1;
    @(posedge clk);
    #1;
    inst_vld = 1'b0;
    while (!ready) begin
      @(posedge clk);
      #1;
    end
    // Written bytes and one beat past the end that keeps its preload
    for (int i = 0; i < len + 8; i++) begin
      a = cur.dst_addr + 32'(i);
      if (i < len) begin
        k = i % 8;
        if (cur.shuffle_en) begin
          k = (k + int'(cur.shuffle_idx)) % 8;
        end
        exp_b = expected_fill(cur.src_port, cur.src_addr + 32'((i / 8) * 8 + k));
      end else begin
        exp_b = expected_fill(cur.dst_port, a);
      end
      act_b = read_mem_byte(cur.dst_port, a);
      if (act_b !== exp_b) begin
        if (bad == 0) begin
          bad_addr = a;
          bad_exp  = exp_b;
          bad_act  = act_b;
        end
        bad++;
      end
    end
    // Bias window writes leave the weight memory alone
    if (cur.dst_port == sdma_pkg::PORT_WC && cur.dst_addr >= sdma_pkg::BMEM_SADDR) begin
      for (int i = 0; i < len + 8; i++) begin
        a = cur.dst_addr - sdma_pkg::BMEM_SADDR + 32'(i);
        exp_b = fill_byte(2, a);
        act_b = u_wmem_mem.mem[a];
        if (act_b !== exp_b) begin
          if (bad == 0) begin
            bad_addr = a;
            bad_exp  = exp_b;
            bad_act  = act_b;
          end
          bad++;
        end
      end
    end
    if (bad != 0) begin
      $display("[FAIL] %0s at %h expected %h actual %h (%0d bytes wrong)",
               test_name[t], bad_addr, bad_exp, bad_act, bad);
      fail_count++;
    end else begin
      $display("[PASS] %0s", test_name[t]);
      pass_count++;
    end
  endtask

  // --------------------
  initial begin
    reset    = 1'b1;
    inst     = '0;
    inst_vld = 1'b0;
    read_patterns();
    if (num_tests == 0) begin
      $display("No tests were read from the pattern file");
      fail_count++;
    end
    for (int t = 0; t < num_tests; t++) begin
      limit += (int'(test_inst[t].length) / 8 + 1) * 30;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    check_reset_state();
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sdma_top.f
logic/sdma_pkg.sv
logic/sdma_top_ctrl.sv
logic/sdma_addr_path.sv
logic/sdma_data_path.sv
logic/sdma_port_mux.sv
logic/sdma_window_demux.sv
logic/sdma_top.sv
testbench/tb_sdma_mem.sv
testbench/tb_sdma_top.sv

// File: testbench/sdma_patterns.txt
# name src_port dst_port src_addr dst_addr length shuffle_en shuffle_idx stall
# ports 0 is DC1, 1 is DC2, 2 is the weight port; addresses in hex, length in bytes
copy_dc1_dc2          0 1 00000100 00000200  29 0 0 0
shuffle_dc1_dc2       0 1 00000300 00000400  40 1 3 0
dc2_to_wmem           1 2 00000800 00000040  32 0 0 0
dc2_to_bmem           1 2 00000900 00001020  24 0 0 0
bmem_to_dc1           2 0 00001100 00000600  21 0 0 0
copy_dc1_dc2_stall    0 1 00000700 00000a00  29 0 0 1
shuffle_stall         0 1 00000b00 00000c00  61 1 5 1
dc2_to_wmem_stall     1 2 00000d00 00000200  48 0 0 1
dc2_to_bmem_stall     1 2 00000e00 00001380  19 0 0 1
bmem_to_dc1_stall     2 0 00001300 00000f00  37 0 0 1
long_shuffle_stall    1 0 00001400 00001800 128 1 7 1
